//--- include/vma_defines.svh
/* Widths and field positions for the VMA stage:
   microword, dispatch word, data path, PC flags and flag word */
`ifndef VMA_DEFINES_SVH
`define VMA_DEFINES_SVH

// Word widths
`define VMA_CROM_WIDTH      24
`define VMA_DROM_WIDTH      8
`define VMA_DP_WIDTH        36
`define VMA_ADDR_WIDTH      22
`define VMA_FLAG_WIDTH      14
`define VMA_CTX_WIDTH       8
`define VMA_PC_WIDTH        18
`define VMA_SPEC_SEL_WIDTH  3

// Microword memory field, bit 0 is the MSB
`define VMA_CROM_MEMCYCLE   0
`define VMA_CROM_LOADVMA    1
`define VMA_CROM_AREAD      2
`define VMA_CROM_BWRITE     3
`define VMA_CROM_WAIT       4
`define VMA_CROM_DPFUNC     5
`define VMA_CROM_EXTADDR    6
`define VMA_CROM_FETCH      7
`define VMA_CROM_PHYSICAL   8
`define VMA_CROM_FORCEUSER  9
`define VMA_CROM_FORCEEXEC  10
`define VMA_CROM_READ       11
`define VMA_CROM_WRTEST     12
`define VMA_CROM_WRITE      13
`define VMA_CROM_CACHEINH   14
// Special function field
`define VMA_CROM_SPECEN20   15
`define VMA_CROM_SPECSEL    16

// Dispatch word
`define VMA_DROM_VMA        0
`define VMA_DROM_CONDFUNC   1
`define VMA_DROM_READ       2
`define VMA_DROM_WRTEST     3
`define VMA_DROM_WRITE      4

// Flag word positions, also the top of the data path word
`define VMA_FLAG_USER       0
`define VMA_FLAG_FETCH      2
`define VMA_FLAG_READ       3
`define VMA_FLAG_WRTEST     4
`define VMA_FLAG_WRITE      5
`define VMA_FLAG_CACHEINH   7
`define VMA_FLAG_PHYSICAL   8
`define VMA_FLAG_PREVIOUS   9
`define VMA_FLAG_IO         10
`define VMA_FLAG_WRU        11
`define VMA_FLAG_VECTOR     12
`define VMA_FLAG_IOBYTE     13

// PC flag bits read by the stage
`define VMA_PC_USER         5
`define VMA_PC_PREVUSER     6

// Context flag order inside the address register
`define VMA_CTX_USER        0
`define VMA_CTX_FETCH       1
`define VMA_CTX_PHYSICAL    2
`define VMA_CTX_PREVIOUS    3
`define VMA_CTX_IO          4
`define VMA_CTX_WRU         5
`define VMA_CTX_VECTOR      6
`define VMA_CTX_IOBYTE      7

`endif

//--- run.sh
#!/usr/bin/env bash
# Build the VMA stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vmaUnit.f --top-module vmaUnitTb -o vmaUnitSim

if ! ./obj_dir/vmaUnitSim > sim.log 2>&1
then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi
cat sim.log

if grep -q "Test failures found" sim.log
then
   exit 1
fi
exit 0

//--- verif/vmaUnitChecker.sv
/* Output checker for the VMA stage: model comparison every cycle,
   per-test lines and the closing counts */
`timescale 1ns/1ps
`default_nettype none

`include "vma_defines.svh"

module vmaUnitChecker
(
   input  wire logic                       clk,
   input  wire logic                       vmaSweep,
   input  wire logic                       vmaExtended,
   input  wire logic [0:`VMA_FLAG_WIDTH-1] vmaFlags,
   input  wire logic [0:`VMA_ADDR_WIDTH-1] vmaAddr,
   input  wire logic                       expSweep,
   input  wire logic                       expExtended,
   input  wire logic [0:`VMA_FLAG_WIDTH-1] expFlags,
   input  wire logic [0:`VMA_ADDR_WIDTH-1] expAddr,
   input  wire logic [7:0]                 testNum,
   input  wire logic                       testDone,
   input  wire logic                       runDone,
   output int                              errorCount,
   output int                              checkCount
);

   // Per-test counters
   int   testErrors;
   int   testChecks;
   // Set once the first clock edge has passed
   logic armed = 1'b0;

   initial
   begin
      errorCount = 0;
      checkCount = 0;
      testErrors = 0;
      testChecks = 0;
   end

   always @(posedge clk)
   begin
      armed <= 1'b1;
   end

   function automatic string testName(input logic [7:0] n);
      case (n)
         8'd1:    return "reset";
         8'd2:    return "address load";
         8'd3:    return "context flags";
         8'd4:    return "cycle type";
         8'd5:    return "cache sweep";
         default: return "unknown";
      endcase
   endfunction

   task automatic countError();
      testErrors++;
      errorCount++;
   endtask

   task automatic compareField(input string name, input logic [`VMA_DP_WIDTH-1:0] expVal,
                               input logic [`VMA_DP_WIDTH-1:0] actVal);
      if (actVal !== expVal)
      begin
         $display("mismatch at %0t: %s expected %h got %h", $time, name, expVal, actVal);
         countError();
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Compare on the falling edge, away from the register updates
   ///////////////////////////////////////////////////////////////////////

   always @(negedge clk)
   begin
      if (armed)
      begin
         testChecks++;
         checkCount++;
         compareField("vmaAddr", 36'(expAddr), 36'(vmaAddr));
         compareField("vmaFlags", 36'(expFlags), 36'(vmaFlags));
         compareField("vmaSweep", 36'(expSweep), 36'(vmaSweep));
         compareField("vmaExtended", 36'(expExtended), 36'(vmaExtended));
         // Unused flag positions
         if (vmaFlags[1] !== 1'b0 || vmaFlags[6] !== 1'b0)
         begin
            $display("vmaFlags bit 1 or bit 6 is set at time %0t", $time);
            countError();
         end
         // No enabled load in the reset test, everything must stay clear
         if (testNum == 8'd1 && (vmaAddr !== '0 || vmaFlags !== '0 ||
                                 vmaSweep !== 1'b0 || vmaExtended !== 1'b0))
         begin
            $display("outputs left the reset state during the reset test at time %0t", $time);
            countError();
         end
         if (testDone)
         begin
            $display("test %0d (%s): %0d checks, %0d errors",
                     testNum, testName(testNum), testChecks, testErrors);
            testErrors = 0;
            testChecks = 0;
         end
         if (runDone)
            $display("total: %0d checks, %0d errors", checkCount, errorCount);
      end
   end

endmodule

`default_nettype wire

//--- verif/vmaUnitTb.sv
/* VMA stage testbench: clock, reset, seeded random stimulus,
   reference model and watchdog */
`timescale 1ns/1ps
`default_nettype none

`include "vma_defines.svh"

module vmaUnitTb
   import vma_pkg::*;
();

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 8;
   localparam int IDLE_CYCLES  = 32;
   localparam int TEST_CYCLES  = 500;
   // Four random tests plus reset, two handshake cycles per test
   localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + 4 * TEST_CYCLES + 5 * 2 + 4;
   localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_PERIOD + 2000;

   logic                       clk;
   logic                       rst;
   logic                       clken;
   logic [0:`VMA_CROM_WIDTH-1] crom;
   logic [0:`VMA_DROM_WIDTH-1] drom;
   dpWordT                     dp;
   logic                       cpuExec;
   logic                       prevEn;
   logic [0:`VMA_PC_WIDTH-1]   pcFlags;
   logic                       vmaSweep;
   logic                       vmaExtended;
   logic [0:`VMA_FLAG_WIDTH-1] vmaFlags;
   logic [0:`VMA_ADDR_WIDTH-1] vmaAddr;
   // Test sequencing
   logic [7:0]                 testNum;
   logic                       testDone;
   logic                       runDone;
   int                         errorCount;
   int                         checkCount;
   int                         seed = 32'h7119_da76;

   vmaUnit vmaUnit_i (
      .clk         (clk),
      .rst         (rst),
      .clken       (clken),
      .crom        (crom),
      .drom        (drom),
      .dp          (dp),
      .cpuExec     (cpuExec),
      .prevEn      (prevEn),
      .pcFlags     (pcFlags),
      .vmaSweep    (vmaSweep),
      .vmaExtended (vmaExtended),
      .vmaFlags    (vmaFlags),
      .vmaAddr     (vmaAddr)
   );

   ///////////////////////////////////////////////////////////////////////
   // Reference model
   ///////////////////////////////////////////////////////////////////////

   logic [`VMA_SPEC_SEL_WIDTH-1:0] mSel;
   logic                           mSweep;
   logic                           mPrev;
   logic                           mUsePrev;
   logic                           mVmaLoad;
   logic                           mMemLoad;
   logic                           mUser;
   logic [0:`VMA_FLAG_WIDTH-1]     mCtxWord;
   logic [0:`VMA_FLAG_WIDTH-1]     mCycWord;
   // Expected registered state
   logic [0:`VMA_FLAG_WIDTH-1]     expCtx;
   logic [0:`VMA_FLAG_WIDTH-1]     expCyc;
   logic [0:`VMA_FLAG_WIDTH-1]     expFlags;
   logic [0:`VMA_ADDR_WIDTH-1]     expAddr;
   logic                           expSweep;
   logic                           expExtended;

   always_comb
   begin
      mSel     = crom[`VMA_CROM_SPECSEL +: `VMA_SPEC_SEL_WIDTH];
      mSweep   = crom[`VMA_CROM_SPECEN20] && (mSel == SPEC_CLRCACHE);
      mPrev    = crom[`VMA_CROM_SPECEN20] && (mSel == SPEC_PREVIOUS);
      mUsePrev = prevEn || mPrev;
      mVmaLoad = (crom[`VMA_CROM_MEMCYCLE] && (crom[`VMA_CROM_LOADVMA] ||
                 (crom[`VMA_CROM_AREAD] && drom[`VMA_DROM_VMA]))) || mSweep;
      mMemLoad = crom[`VMA_CROM_MEMCYCLE] && (crom[`VMA_CROM_WAIT] ||
                 (crom[`VMA_CROM_BWRITE] && drom[`VMA_DROM_CONDFUNC]));
      mUser    = (!crom[`VMA_CROM_FORCEEXEC] && pcFlags[`VMA_PC_USER] && !cpuExec) ||
                 (crom[`VMA_CROM_FETCH] && pcFlags[`VMA_PC_USER]) ||
                 (mUsePrev && pcFlags[`VMA_PC_PREVUSER]) || crom[`VMA_CROM_FORCEUSER];
      // Context part of the flag word
      mCtxWord = '0;
      if (crom[`VMA_CROM_DPFUNC])
      begin
         mCtxWord                     = dp.vmaView.flags;
         mCtxWord[1]                  = 1'b0;
         mCtxWord[6]                  = 1'b0;
         mCtxWord[`VMA_FLAG_READ]     = 1'b0;
         mCtxWord[`VMA_FLAG_WRTEST]   = 1'b0;
         mCtxWord[`VMA_FLAG_WRITE]    = 1'b0;
         mCtxWord[`VMA_FLAG_CACHEINH] = 1'b0;
      end
      else
      begin
         mCtxWord[`VMA_FLAG_USER]     = mUser;
         mCtxWord[`VMA_FLAG_FETCH]    = crom[`VMA_CROM_FETCH];
         mCtxWord[`VMA_FLAG_PHYSICAL] = crom[`VMA_CROM_PHYSICAL];
         mCtxWord[`VMA_FLAG_PREVIOUS] = mUsePrev;
      end
      // Cycle-type part, three sources in priority order
      mCycWord = '0;
      if (crom[`VMA_CROM_AREAD])
      begin
         mCycWord[`VMA_FLAG_READ]     = drom[`VMA_DROM_READ];
         mCycWord[`VMA_FLAG_WRTEST]   = drom[`VMA_DROM_WRTEST];
         mCycWord[`VMA_FLAG_WRITE]    = drom[`VMA_DROM_WRITE];
      end
      else if (crom[`VMA_CROM_DPFUNC])
      begin
         mCycWord[`VMA_FLAG_READ]     = dp.raw[`VMA_FLAG_READ];
         mCycWord[`VMA_FLAG_WRTEST]   = dp.raw[`VMA_FLAG_WRTEST];
         mCycWord[`VMA_FLAG_WRITE]    = dp.raw[`VMA_FLAG_WRITE];
         mCycWord[`VMA_FLAG_CACHEINH] = dp.raw[`VMA_FLAG_CACHEINH];
      end
      else
      begin
         mCycWord[`VMA_FLAG_READ]     = crom[`VMA_CROM_READ];
         mCycWord[`VMA_FLAG_WRTEST]   = crom[`VMA_CROM_WRTEST];
         mCycWord[`VMA_FLAG_WRITE]    = crom[`VMA_CROM_WRITE];
         mCycWord[`VMA_FLAG_CACHEINH] = crom[`VMA_CROM_CACHEINH];
      end
   end

   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         expAddr     <= '0;
         expSweep    <= 1'b0;
         expExtended <= 1'b0;
         expCtx      <= '0;
         expCyc      <= '0;
      end
      else if (clken)
      begin
         if (mVmaLoad)
         begin
            expAddr     <= dp.vmaView.addr;
            expSweep    <= mSweep;
            expExtended <= crom[`VMA_CROM_EXTADDR];
            expCtx      <= mCtxWord;
         end
         // Independent of the address load
         if (mMemLoad)
            expCyc <= mCycWord;
      end
   end

   assign expFlags = expCtx | expCyc;

   vmaUnitChecker outputCheck_i (
      .clk         (clk),
      .vmaSweep    (vmaSweep),
      .vmaExtended (vmaExtended),
      .vmaFlags    (vmaFlags),
      .vmaAddr     (vmaAddr),
      .expSweep    (expSweep),
      .expExtended (expExtended),
      .expFlags    (expFlags),
      .expAddr     (expAddr),
      .testNum     (testNum),
      .testDone    (testDone),
      .runDone     (runDone),
      .errorCount  (errorCount),
      .checkCount  (checkCount)
   );

   ///////////////////////////////////////////////////////////////////////
   // Stimulus
   ///////////////////////////////////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // True with the given percentage
   function automatic logic chance(input int pct);
      logic [31:0] r;
      r = $random(seed);
      return (r % 32'd100) < pct;
   endfunction

   // One random input set per rising edge, biased by test
   task automatic driveCycle(input logic [7:0] test);
      logic [31:0]                r;
      logic [63:0]                w;
      logic [0:`VMA_CROM_WIDTH-1] c;
      dpWordT                     d;
      r = $random(seed);
      c = r[`VMA_CROM_WIDTH-1:0];
      c[`VMA_CROM_MEMCYCLE] = chance(70);
      if (test == 8'd2)
         c[`VMA_CROM_LOADVMA] = chance(60);
      if (test == 8'd3)
      begin
         c[`VMA_CROM_DPFUNC] = chance(50);
         if (chance(30))
         begin
            c[`VMA_CROM_SPECEN20] = 1'b1;
            c[`VMA_CROM_SPECSEL +: `VMA_SPEC_SEL_WIDTH] = SPEC_PREVIOUS;
         end
      end
      if (test == 8'd4)
      begin
         c[`VMA_CROM_WAIT]   = chance(50);
         c[`VMA_CROM_AREAD]  = chance(40);
         c[`VMA_CROM_DPFUNC] = chance(50);
      end
      if (test == 8'd5)
      begin
         // Sweeps with and without a memory cycle
         c[`VMA_CROM_MEMCYCLE] = chance(40);
         if (chance(50))
         begin
            c[`VMA_CROM_SPECEN20] = 1'b1;
            c[`VMA_CROM_SPECSEL +: `VMA_SPEC_SEL_WIDTH] = SPEC_CLRCACHE;
         end
      end
      w = {$random(seed), $random(seed)};
      d.raw = w[`VMA_DP_WIDTH-1:0];
      @(posedge clk);
      crom    <= c;
      dp      <= d;
      clken   <= (test == 8'd1) ? 1'b0 : chance(70);
      prevEn  <= chance(25);
      r = $random(seed);
      drom    <= r[`VMA_DROM_WIDTH-1:0];
      pcFlags <= r[`VMA_DROM_WIDTH +: `VMA_PC_WIDTH];
      cpuExec <= r[31];
   endtask

   task automatic runTest(input logic [7:0] test, input int cycles);
      int i;
      testNum <= test;
      for (i = 0; i < cycles; i++)
         driveCycle(test);
      @(posedge clk);
      testDone <= 1'b1;
      @(posedge clk);
      testDone <= 1'b0;
   endtask

   initial
   begin
      int i;
      rst      = 1'b1;
      clken    = 1'b0;
      crom     = '0;
      drom     = '0;
      dp       = '0;
      cpuExec  = 1'b0;
      prevEn   = 1'b0;
      pcFlags  = '0;
      testNum  = 8'd1;
      testDone = 1'b0;
      runDone  = 1'b0;
      // Random inputs keep moving under reset
      for (i = 0; i < RESET_CYCLES; i++)
         driveCycle(8'd1);
      rst <= 1'b0;
      runTest(8'd1, IDLE_CYCLES);
      runTest(8'd2, TEST_CYCLES);
      runTest(8'd3, TEST_CYCLES);
      runTest(8'd4, TEST_CYCLES);
      runTest(8'd5, TEST_CYCLES);
      @(posedge clk);
      runDone <= 1'b1;
      @(posedge clk);
      runDone <= 1'b0;
      @(posedge clk);
      if (errorCount == 0 && checkCount > 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   // Watchdog sized from the test lengths
   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/memCycleCtl.sv
/* Memory cycle-type flag register, loaded from the dispatch word,
   the data path or the microword */
`timescale 1ns/1ps
`default_nettype none

`include "vma_defines.svh"

module memCycleCtl
   import vma_pkg::*;
(
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       clken,
   input  wire logic                       memLoad,
   input  wire logic [0:`VMA_CROM_WIDTH-1] crom,
   input  wire logic [0:`VMA_DROM_WIDTH-1] drom,
   input  wire dpWordT                     dp,
   output logic                            readCycle,
   output logic                            wrTestCycle,
   output logic                            writeCycle,
   output logic                            cacheInh
);

   ///////////////////////////////////////////////////////////////////////
   // Cycle type register
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         readCycle   <= 1'b0;
         wrTestCycle <= 1'b0;
         writeCycle  <= 1'b0;
         cacheInh    <= 1'b0;
      end
      else if (clken && memLoad)
      begin
         if (crom[`VMA_CROM_AREAD])
         begin
            // Dispatch decides the cycle, always cached
            readCycle   <= drom[`VMA_DROM_READ];
            wrTestCycle <= drom[`VMA_DROM_WRTEST];
            writeCycle  <= drom[`VMA_DROM_WRITE];
            cacheInh    <= 1'b0;
         end
         else if (crom[`VMA_CROM_DPFUNC])
         begin
            // Flag bits sit at the top of the raw word
            readCycle   <= dp.raw[`VMA_FLAG_READ];
            wrTestCycle <= dp.raw[`VMA_FLAG_WRTEST];
            writeCycle  <= dp.raw[`VMA_FLAG_WRITE];
            cacheInh    <= dp.raw[`VMA_FLAG_CACHEINH];
         end
         else
         begin
            // Microcode chooses directly
            readCycle   <= crom[`VMA_CROM_READ];
            wrTestCycle <= crom[`VMA_CROM_WRTEST];
            writeCycle  <= crom[`VMA_CROM_WRITE];
            cacheInh    <= crom[`VMA_CROM_CACHEINH];
         end
      end
   end

   // No cycle type pending on the first clock after reset
   clearAfterReset: assert property (@(posedge clk)
      $fell(rst) |-> !(readCycle || wrTestCycle || writeCycle || cacheInh))
      else $error("Cycle flags set after reset release");

endmodule

`default_nettype wire

//--- verilog/vmaAddrReg.sv
/* VMA address register, sweep and extended bits, context flag register
   with the user-mode computation */
`timescale 1ns/1ps
`default_nettype none

`include "vma_defines.svh"

module vmaAddrReg
   import vma_pkg::*;
(
   input  wire logic                           clk,
   input  wire logic                           rst,
   input  wire logic                           clken,
   input  wire logic                           vmaLoad,
   input  wire logic                           cacheSweep,
   input  wire logic                           selPrevious,
   input  wire logic [0:`VMA_CROM_WIDTH-1]     crom,
   input  wire dpWordT                         dp,
   input  wire logic                           cpuExec,
   input  wire logic                           prevEn,
   input  wire logic [0:`VMA_PC_WIDTH-1]       pcFlags,
   output logic      [0:`VMA_ADDR_WIDTH-1]     vmaAddr,
   output logic                                vmaSweep,
   output logic                                vmaExtended,
   output logic      [0:`VMA_CTX_WIDTH-1]      ctxFlags
);

   // PC flag bits
   logic pcUser;
   logic pcPrevUser;
   // Previous context in use this cycle
   logic usePrev;
   logic userNext;
   logic [0:`VMA_CTX_WIDTH-1] ctxNext;

   assign pcUser     = pcFlags[`VMA_PC_USER];
   assign pcPrevUser = pcFlags[`VMA_PC_PREVUSER];
   assign usePrev    = prevEn || selPrevious;

   ///////////////////////////////////////////////////////////////////////
   // User mode
   ///////////////////////////////////////////////////////////////////////

   // User unless forced to exec or running in exec
   // Fetches follow the PC user bit
   // Previous context takes the previous-user bit
   assign userNext = (!crom[`VMA_CROM_FORCEEXEC] && pcUser && !cpuExec) ||
                     (crom[`VMA_CROM_FETCH] && pcUser) ||
                     (usePrev && pcPrevUser) ||
                     crom[`VMA_CROM_FORCEUSER];

   ///////////////////////////////////////////////////////////////////////
   // Context flag source
   ///////////////////////////////////////////////////////////////////////

   always_comb
   begin
      ctxNext = '0;
      if (crom[`VMA_CROM_DPFUNC])
      begin
         // Flags supplied by the data path
         ctxNext[`VMA_CTX_USER]     = dp.vmaView.flags[`VMA_FLAG_USER];
         ctxNext[`VMA_CTX_FETCH]    = dp.vmaView.flags[`VMA_FLAG_FETCH];
         ctxNext[`VMA_CTX_PHYSICAL] = dp.vmaView.flags[`VMA_FLAG_PHYSICAL];
         ctxNext[`VMA_CTX_PREVIOUS] = dp.vmaView.flags[`VMA_FLAG_PREVIOUS];
         ctxNext[`VMA_CTX_IO]       = dp.vmaView.flags[`VMA_FLAG_IO];
         ctxNext[`VMA_CTX_WRU]      = dp.vmaView.flags[`VMA_FLAG_WRU];
         ctxNext[`VMA_CTX_VECTOR]   = dp.vmaView.flags[`VMA_FLAG_VECTOR];
         ctxNext[`VMA_CTX_IOBYTE]   = dp.vmaView.flags[`VMA_FLAG_IOBYTE];
      end
      else
      begin
         // Computed flags; I/O class stays clear
         ctxNext[`VMA_CTX_USER]     = userNext;
         ctxNext[`VMA_CTX_FETCH]    = crom[`VMA_CROM_FETCH];
         ctxNext[`VMA_CTX_PHYSICAL] = crom[`VMA_CROM_PHYSICAL];
         ctxNext[`VMA_CTX_PREVIOUS] = usePrev;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Register
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         vmaAddr     <= '0;
         vmaSweep    <= 1'b0;
         vmaExtended <= 1'b0;
         ctxFlags    <= '0;
      end
      else if (clken && vmaLoad)
      begin
         vmaAddr     <= dp.vmaView.addr;
         // Sweep only on a cache clear, cleared by any other load
         vmaSweep    <= cacheSweep;
         vmaExtended <= crom[`VMA_CROM_EXTADDR];
         ctxFlags    <= ctxNext;
      end
   end

   // Disabled clock freezes every output
   holdWhileIdle: assert property (@(posedge clk) disable iff (rst)
      !clken |=> ($stable(vmaAddr) && $stable(vmaSweep) &&
                  $stable(vmaExtended) && $stable(ctxFlags)))
      else $error("VMA register changed with clken low");

endmodule

`default_nettype wire

//--- verilog/vmaMicroDecode.sv
/* Microword and dispatch decode into the VMA and memory load enables
   plus the cache sweep and previous-context strobes */
`timescale 1ns/1ps
`default_nettype none

`include "vma_defines.svh"

module vmaMicroDecode
   import vma_pkg::*;
(
   input  wire logic [0:`VMA_CROM_WIDTH-1] crom,
   input  wire logic [0:`VMA_DROM_WIDTH-1] drom,
   output logic                            vmaLoad,
   output logic                            memLoad,
   output logic                            cacheSweep,
   output logic                            selPrevious
);

   ///////////////////////////////////////////////////////////////////////
   // Microword field pickoff
   ///////////////////////////////////////////////////////////////////////

   logic    memCycle;
   logic    loadVma;
   logic    aRead;
   logic    bWrite;
   logic    memWait;
   logic    specEn20;
   specSelT specSel;

   assign memCycle = crom[`VMA_CROM_MEMCYCLE];
   assign loadVma  = crom[`VMA_CROM_LOADVMA];
   assign aRead    = crom[`VMA_CROM_AREAD];
   assign bWrite   = crom[`VMA_CROM_BWRITE];
   assign memWait  = crom[`VMA_CROM_WAIT];
   assign specEn20 = crom[`VMA_CROM_SPECEN20];
   // 3-bit select read through the enum
   assign specSel  = specSelT'(crom[`VMA_CROM_SPECSEL +: `VMA_SPEC_SEL_WIDTH]);

   ///////////////////////////////////////////////////////////////////////
   // Special function strobes
   ///////////////////////////////////////////////////////////////////////

   // Cache clear also forces an address load
   assign cacheSweep  = specEn20 && (specSel == SPEC_CLRCACHE);
   // Selects the previous context for this cycle
   assign selPrevious = specEn20 && (specSel == SPEC_PREVIOUS);

   ///////////////////////////////////////////////////////////////////////
   // Load enables
   ///////////////////////////////////////////////////////////////////////

   // Address load
   // Direct microcode load or a dispatch-controlled read
   assign vmaLoad = (memCycle && loadVma) ||
                    (memCycle && aRead && drom[`VMA_DROM_VMA]) ||
                    cacheSweep;

   // Cycle-type load
   // Microcode wait or a write conditioned by the dispatch word
   assign memLoad = (memCycle && memWait) ||
                    (memCycle && bWrite && drom[`VMA_DROM_CONDFUNC]);

endmodule

`default_nettype wire

//--- verilog/vmaUnit.sv
/* VMA stage top level: decode, address register, cycle control
   and flag word assembly */
`timescale 1ns/1ps
`default_nettype none

`include "vma_defines.svh"

module vmaUnit
   import vma_pkg::*;
(
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       clken,
   input  wire logic [0:`VMA_CROM_WIDTH-1] crom,
   input  wire logic [0:`VMA_DROM_WIDTH-1] drom,
   input  wire dpWordT                     dp,
   input  wire logic                       cpuExec,
   input  wire logic                       prevEn,
   input  wire logic [0:`VMA_PC_WIDTH-1]   pcFlags,
   output logic                            vmaSweep,
   output logic                            vmaExtended,
   output logic      [0:`VMA_FLAG_WIDTH-1] vmaFlags,
   output logic      [0:`VMA_ADDR_WIDTH-1] vmaAddr
);

   // Decode strobes
   logic vmaLoad;
   logic memLoad;
   logic cacheSweep;
   logic selPrevious;
   // Registered flags
   logic [0:`VMA_CTX_WIDTH-1] ctxFlags;
   logic readCycle;
   logic wrTestCycle;
   logic writeCycle;
   logic cacheInh;

   vmaMicroDecode decode_i (
      .crom        (crom),
      .drom        (drom),
      .vmaLoad     (vmaLoad),
      .memLoad     (memLoad),
      .cacheSweep  (cacheSweep),
      .selPrevious (selPrevious)
   );

   vmaAddrReg addrReg_i (
      .clk         (clk),
      .rst         (rst),
      .clken       (clken),
      .vmaLoad     (vmaLoad),
      .cacheSweep  (cacheSweep),
      .selPrevious (selPrevious),
      .crom        (crom),
      .dp          (dp),
      .cpuExec     (cpuExec),
      .prevEn      (prevEn),
      .pcFlags     (pcFlags),
      .vmaAddr     (vmaAddr),
      .vmaSweep    (vmaSweep),
      .vmaExtended (vmaExtended),
      .ctxFlags    (ctxFlags)
   );

   memCycleCtl memCtl_i (
      .clk         (clk),
      .rst         (rst),
      .clken       (clken),
      .memLoad     (memLoad),
      .crom        (crom),
      .drom        (drom),
      .dp          (dp),
      .readCycle   (readCycle),
      .wrTestCycle (wrTestCycle),
      .writeCycle  (writeCycle),
      .cacheInh    (cacheInh)
   );

   ///////////////////////////////////////////////////////////////////////
   // Flag word
   ///////////////////////////////////////////////////////////////////////

   // Bits 1 and 6 are unused and stay zero
   always_comb
   begin
      vmaFlags                      = '0;
      vmaFlags[`VMA_FLAG_USER]      = ctxFlags[`VMA_CTX_USER];
      vmaFlags[`VMA_FLAG_FETCH]     = ctxFlags[`VMA_CTX_FETCH];
      vmaFlags[`VMA_FLAG_READ]      = readCycle;
      vmaFlags[`VMA_FLAG_WRTEST]    = wrTestCycle;
      vmaFlags[`VMA_FLAG_WRITE]     = writeCycle;
      vmaFlags[`VMA_FLAG_CACHEINH]  = cacheInh;
      vmaFlags[`VMA_FLAG_PHYSICAL]  = ctxFlags[`VMA_CTX_PHYSICAL];
      vmaFlags[`VMA_FLAG_PREVIOUS]  = ctxFlags[`VMA_CTX_PREVIOUS];
      // I/O class
      vmaFlags[`VMA_FLAG_IO]        = ctxFlags[`VMA_CTX_IO];
      vmaFlags[`VMA_FLAG_WRU]       = ctxFlags[`VMA_CTX_WRU];
      vmaFlags[`VMA_FLAG_VECTOR]    = ctxFlags[`VMA_CTX_VECTOR];
      vmaFlags[`VMA_FLAG_IOBYTE]    = ctxFlags[`VMA_CTX_IOBYTE];
   end

endmodule

`default_nettype wire

//--- verilog/vma_pkg.sv
/* Types of the VMA stage: data path word union and special-select codes */
`default_nettype none

`include "vma_defines.svh"

package vma_pkg;

   // Address-stage view of a data path word
   // Flags occupy the upper 14 bits, address the lower 22
   typedef struct packed
   {
      logic [0:`VMA_FLAG_WIDTH-1] flags;
      logic [0:`VMA_ADDR_WIDTH-1] addr;
   } vmaViewT;

   // Same 36 bits, read as plain data or as flags plus address
   typedef union packed
   {
      logic [0:`VMA_DP_WIDTH-1] raw;
      vmaViewT                  vmaView;
   } dpWordT;

   ///////////////////////////////////////////////////////////////////////
   // Special function select, valid when the 20 enable is set
   ///////////////////////////////////////////////////////////////////////

   // Only CLRCACHE and PREVIOUS act on this stage
   typedef enum logic [`VMA_SPEC_SEL_WIDTH-1:0]
   {
      SPEC_NOP      = 3'd0,
      SPEC_CLRCLK   = 3'd1,
      SPEC_PREVIOUS = 3'd2,
      SPEC_LOADAPR  = 3'd3,
      SPEC_PXCT     = 3'd4,
      SPEC_LOADPI   = 3'd5,
      SPEC_NICOND   = 3'd6,
      SPEC_CLRCACHE = 3'd7
   } specSelT;

endpackage

`default_nettype wire

//--- vmaUnit.f
+incdir+include
verilog/vma_pkg.sv
verilog/vmaMicroDecode.sv
verilog/vmaAddrReg.sv
verilog/memCycleCtl.sv
verilog/vmaUnit.sv
verif/vmaUnitChecker.sv
verif/vmaUnitTb.sv
